// ==== rtl/memsys_pkg.sv ====
`default_nettype none

// shared widths and bus structs for the memory side

package memsys_pkg;

  // ************************************************************
  // widths
  // ************************************************************

  // one word of address, byte-free addressing
  localparam int unsigned addr_w = 8;

  // one word of data
  localparam int unsigned data_w = 32;

  // arbiter ports
  // port 0 is the host, port 1 is the fill engine
  localparam int unsigned n_clients = 2;

  // ************************************************************
  // request and response
  // ************************************************************

  // request from a client toward the memory, 41 bits
  typedef struct packed {
    // 1 = write, 0 = read
    logic              we;
    // word address
    logic [addr_w-1:0] addr;
    // write data, ignored on reads
    logic [data_w-1:0] wdata;
  } mem_req_t;

  // read response from the memory, 33 bits
  typedef struct packed {
    // high for one cycle, the cycle after the read
    logic              rvalid;
    // word read back
    logic [data_w-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/rst_sequencer.sv ====
`default_nettype none

// reset sequencer for the half-rate logic
// asserts asynchronously, releases a fixed number of edges later

module rst_sequencer #(
  parameter int RST_ACT_LOW  = 1,
  parameter int RST_SYNC_NUM = 15
) (
  input  logic clk_bufg,
  input  logic sys_rst,
  input  logic pll_lock,
  input  logic iodelay_ctrl_rdy,
  output logic rstdiv0
);

  // half of the full-rate count, rounded up
  // so the divided clock never leaves reset before the fast one
  localparam int RST_DIV_SYNC_NUM = (RST_SYNC_NUM + 1) / 2;

  logic                        sys_rst_act_hi;
  logic                        rst_tmp;
  logic [RST_DIV_SYNC_NUM-1:0] rstdiv0_sync_r;

  // ************************************************************
  // reset sources
  // ************************************************************

  // bring the system reset to active high
  assign sys_rst_act_hi = (RST_ACT_LOW != 0) ? ~sys_rst : sys_rst;

  // hold reset until the clock manager is locked
  // and the delay controller reports ready
  assign rst_tmp = sys_rst_act_hi | ~pll_lock | ~iodelay_ctrl_rdy;

  // ************************************************************
  // release stretch
  // ************************************************************

  // all ones while any source is active, no clock needed
  // after release zeros march toward the last stage,
  // one stage per edge
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      rstdiv0_sync_r <= '1;
    end else begin
      rstdiv0_sync_r <= rstdiv0_sync_r << 1;
    end
  end

  // last stage drops on edge number RST_DIV_SYNC_NUM
  assign rstdiv0 = rstdiv0_sync_r[RST_DIV_SYNC_NUM-1];

endmodule

`default_nettype wire

// ==== rtl/mem_array.sv ====
`default_nettype none

// single-port word memory, read data registered

module mem_array
  import memsys_pkg::*;
#(
  parameter int DEPTH = 256
) (
  input  logic     clk_bufg,
  input  logic     rst_tmp,
  input  logic     mem_en,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  // index bits, upper address bits are dropped
  localparam int IDX_W = $clog2(DEPTH);

  logic [data_w-1:0] mem [DEPTH];
  logic [IDX_W-1:0]  idx;
  logic              rvalid_r;
  logic [data_w-1:0] rdata_r;

  // address modulo DEPTH
  assign idx = mem_req.addr[IDX_W-1:0];

  // storage and read register, no reset on either
  always_ff @(posedge clk_bufg) begin
    if (mem_en) begin
      if (mem_req.we) begin
        mem[idx] <= mem_req.wdata;
      end else begin
        rdata_r <= mem[idx];
      end
    end
  end

  // read valid, one cycle after an enabled read
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      rvalid_r <= 1'b0;
    end else begin
      rvalid_r <= mem_en && !mem_req.we;
    end
  end

  assign mem_rsp.rvalid = rvalid_r;
  assign mem_rsp.rdata  = rdata_r;

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`default_nettype none

// round-robin arbiter in front of the single-port memory
// grants at most one client per cycle and steers read data back

module mem_arbiter
  import memsys_pkg::*;
(
  input  logic                           clk_bufg,
  input  logic                           rst_tmp,
  input  logic     [n_clients-1:0]       req_valid,
  input  mem_req_t [n_clients-1:0]       req,
  output logic     [n_clients-1:0]       grant,
  output logic                           mem_en,
  output mem_req_t                       mem_req,
  input  mem_rsp_t                       mem_rsp,
  output mem_rsp_t [n_clients-1:0]       rsp
);

  // port granted most recently
  logic last_port;
  // port whose read is in flight in the memory
  logic rd_owner;

  // ************************************************************
  // grant select
  // ************************************************************

  // combinational, same cycle as the request
  // on a tie the port not served last wins
  always_comb begin
    unique case (req_valid)
      2'b01:   grant = 2'b01;
      2'b10:   grant = 2'b10;
      2'b11:   grant = last_port ? 2'b01 : 2'b10;
      default: grant = 2'b00;
    endcase
  end

  // one client reaches the memory per cycle
  assign mem_en  = |grant;
  assign mem_req = grant[1] ? req[1] : req[0];

  // ************************************************************
  // round-robin and read ownership state
  // ************************************************************

  // last_port starts at 1 so the host goes first after reset
  // rd_owner only moves on a granted read, so a response
  // still returning keeps its owner for exactly one more cycle
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      last_port <= 1'b1;
      rd_owner  <= 1'b0;
    end else if (mem_en) begin
      last_port <= grant[1];
      if (!mem_req.we) begin
        rd_owner <= grant[1];
      end
    end
  end

  // ************************************************************
  // response routing
  // ************************************************************

  // data goes to every port, rvalid only to the owner
  always_comb begin
    for (int i = 0; i < n_clients; i++) begin
      rsp[i].rvalid = mem_rsp.rvalid && (rd_owner == 1'(i));
      rsp[i].rdata  = mem_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/host_port.sv ====
`default_nettype none

// host client, one command at a time

module host_port
  import memsys_pkg::*;
(
  input  logic              clk_bufg,
  input  logic              rst_tmp,
  input  logic              host_cmd_valid,
  input  mem_req_t          host_cmd,
  output logic              host_busy,
  output logic              host_rdata_valid,
  output logic [data_w-1:0] host_rdata,
  output logic              req_valid,
  output mem_req_t          req,
  input  logic              grant,
  input  mem_rsp_t          rsp
);

  // captured command, payload only
  mem_req_t cmd_r;
  // request still waiting for its grant
  logic     pend_r;
  // read granted, response not yet back
  logic     rd_wait_r;
  logic     accept;

  // new command only while idle
  assign accept = host_cmd_valid && !host_busy;

  // ************************************************************
  // control
  // ************************************************************

  // busy covers capture, grant wait and the read return
  // a write finishes at the grant edge, a read when its data lands
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      host_busy        <= 1'b0;
      pend_r           <= 1'b0;
      rd_wait_r        <= 1'b0;
      host_rdata_valid <= 1'b0;
    end else begin
      host_rdata_valid <= 1'b0;
      if (accept) begin
        host_busy <= 1'b1;
        pend_r    <= 1'b1;
      end else if (pend_r && grant) begin
        pend_r <= 1'b0;
        if (cmd_r.we) begin
          host_busy <= 1'b0;
        end else begin
          rd_wait_r <= 1'b1;
        end
      end else if (rd_wait_r && rsp.rvalid) begin
        rd_wait_r        <= 1'b0;
        host_busy        <= 1'b0;
        host_rdata_valid <= 1'b1;
      end
    end
  end

  // ************************************************************
  // payload
  // ************************************************************

  always_ff @(posedge clk_bufg) begin
    if (accept) begin
      cmd_r <= host_cmd;
    end
    // arbiter only raises rvalid here for our own read
    if (rd_wait_r && rsp.rvalid) begin
      host_rdata <= rsp.rdata;
    end
  end

  // held unchanged until granted
  assign req_valid = pend_r;
  assign req       = cmd_r;

endmodule

`default_nettype wire

// ==== rtl/fill_engine.sv ====
`default_nettype none

// pattern fill, writes seed + offset to base + offset

module fill_engine
  import memsys_pkg::*;
(
  input  logic              clk_bufg,
  input  logic              rst_tmp,
  input  logic              fill_start,
  input  logic [addr_w-1:0] fill_base,
  input  logic [addr_w:0]   fill_len,
  input  logic [data_w-1:0] fill_seed,
  output logic              fill_busy,
  output logic              fill_done,
  output logic              req_valid,
  output mem_req_t          req,
  input  logic              grant
);

  // captured fill job, payload only
  logic [addr_w-1:0] base_r;
  logic [addr_w:0]   len_r;
  logic [data_w-1:0] seed_r;

  // offset into the range, 0 to len - 1
  logic [addr_w:0]   off_r;
  logic [addr_w:0]   off_nxt;
  logic              last;
  logic              accept;

  assign accept  = fill_start && !fill_busy;
  assign off_nxt = off_r + 1'b1;
  // this grant covers the final address
  assign last    = (off_nxt == len_r);

  // ************************************************************
  // control
  // ************************************************************

  // counter moves only on grant, contention just stretches the fill
  // zero length skips the busy phase and reports done at once
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      fill_busy <= 1'b0;
      fill_done <= 1'b0;
      off_r     <= '0;
    end else begin
      fill_done <= 1'b0;
      if (accept) begin
        off_r <= '0;
        if (fill_len == '0) begin
          fill_done <= 1'b1;
        end else begin
          fill_busy <= 1'b1;
        end
      end else if (fill_busy && grant) begin
        if (last) begin
          fill_busy <= 1'b0;
          fill_done <= 1'b1;
        end else begin
          off_r <= off_nxt;
        end
      end
    end
  end

  // ************************************************************
  // job capture and request
  // ************************************************************

  always_ff @(posedge clk_bufg) begin
    if (accept) begin
      base_r <= fill_base;
      len_r  <= fill_len;
      seed_r <= fill_seed;
    end
  end

  assign req_valid = fill_busy;
  assign req.we    = 1'b1;
  // address wraps at 256 through the 8 bit add
  assign req.addr  = base_r + off_r[addr_w-1:0];
  assign req.wdata = seed_r + data_w'(off_r);

endmodule

`default_nettype wire

// ==== rtl/memsys_top.sv ====
`default_nettype none

// half-rate memory side, reset sequencer plus two clients on one memory

module memsys_top
  import memsys_pkg::*;
#(
  parameter int RST_ACT_LOW  = 1,
  parameter int RST_SYNC_NUM = 15,
  parameter int DEPTH        = 256
) (
  input  logic              clk_bufg,
  input  logic              sys_rst,
  input  logic              pll_lock,
  input  logic              iodelay_ctrl_rdy,
  output logic              rstdiv0,
  // host command port
  input  logic              host_cmd_valid,
  input  mem_req_t          host_cmd,
  output logic              host_busy,
  output logic              host_rdata_valid,
  output logic [data_w-1:0] host_rdata,
  // fill control
  input  logic              fill_start,
  input  logic [addr_w-1:0] fill_base,
  input  logic [addr_w:0]   fill_len,
  input  logic [data_w-1:0] fill_seed,
  output logic              fill_busy,
  output logic              fill_done
);

  // client side of the arbiter, index 0 host, 1 fill
  logic     [n_clients-1:0] req_valid;
  mem_req_t [n_clients-1:0] req;
  logic     [n_clients-1:0] grant;
  mem_rsp_t [n_clients-1:0] rsp;

  // memory side of the arbiter
  logic                     mem_en;
  mem_req_t                 mem_req;
  mem_rsp_t                 mem_rsp;

  // ************************************************************
  // reset
  // ************************************************************

  rst_sequencer #(
    .RST_ACT_LOW  (RST_ACT_LOW),
    .RST_SYNC_NUM (RST_SYNC_NUM)
  ) u_rst_sequencer (
    .clk_bufg         (clk_bufg),
    .sys_rst          (sys_rst),
    .pll_lock         (pll_lock),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .rstdiv0          (rstdiv0)
  );

  // ************************************************************
  // clients, arbiter and memory
  // ************************************************************

  host_port u_host_port (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rstdiv0),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd         (host_cmd),
    .host_busy        (host_busy),
    .host_rdata_valid (host_rdata_valid),
    .host_rdata       (host_rdata),
    .req_valid        (req_valid[0]),
    .req              (req[0]),
    .grant            (grant[0]),
    .rsp              (rsp[0])
  );

  // fill engine only writes, its response lane stays unused
  fill_engine u_fill_engine (
    .clk_bufg   (clk_bufg),
    .rst_tmp    (rstdiv0),
    .fill_start (fill_start),
    .fill_base  (fill_base),
    .fill_len   (fill_len),
    .fill_seed  (fill_seed),
    .fill_busy  (fill_busy),
    .fill_done  (fill_done),
    .req_valid  (req_valid[1]),
    .req        (req[1]),
    .grant      (grant[1])
  );

  mem_arbiter u_mem_arbiter (
    .clk_bufg  (clk_bufg),
    .rst_tmp   (rstdiv0),
    .req_valid (req_valid),
    .req       (req),
    .grant     (grant),
    .mem_en    (mem_en),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .rsp       (rsp)
  );

  mem_array #(
    .DEPTH (DEPTH)
  ) u_mem_array (
    .clk_bufg (clk_bufg),
    .rst_tmp  (rstdiv0),
    .mem_en   (mem_en),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

endmodule

`default_nettype wire

// ==== tb/memsys_assert.sv ====
`default_nettype none

// protocol checks on the arbiter ports

module memsys_assert
  import memsys_pkg::*;
(
  input logic                     clk_bufg,
  input logic                     rst_tmp,
  input logic     [n_clients-1:0] req_valid,
  input mem_req_t [n_clients-1:0] req,
  input logic     [n_clients-1:0] grant,
  input mem_rsp_t [n_clients-1:0] rsp
);

  // at most one port reaches the memory
  grant_onehot: assert property (@(posedge clk_bufg) disable iff (rst_tmp)
    $onehot0(grant)) else $error("grant is not one-hot: %b", grant);

  // no grant without a request
  grant_has_req: assert property (@(posedge clk_bufg) disable iff (rst_tmp)
    (grant & ~req_valid) == '0) else $error("grant %b without request %b", grant, req_valid);

  // read data only returns to the port whose read was granted one cycle before
  for (genvar i = 0; i < n_clients; i++) begin : g_rvalid
    rvalid_after_read: assert property (@(posedge clk_bufg) disable iff (rst_tmp)
      rsp[i].rvalid |-> $past(grant[i] && !req[i].we))
      else $error("rvalid on port %0d without a read grant", i);
  end

endmodule

bind mem_arbiter memsys_assert u_memsys_assert (
  .clk_bufg  (clk_bufg),
  .rst_tmp   (rst_tmp),
  .req_valid (req_valid),
  .req       (req),
  .grant     (grant),
  .rsp       (rsp)
);

`default_nettype wire

// ==== tb/memsys_tb.sv ====
`default_nettype none

// testbench for the memory side, table driven with a reference memory

module memsys_tb
  import memsys_pkg::*;
();

  localparam int rst_sync_num = 15;
  // release edges, half the base count rounded up
  localparam int rel_edges    = (rst_sync_num + 1) / 2;
  localparam int n_rows       = 13;
  localparam int clk_period   = 20;
  localparam int wait_limit   = 300;
  localparam int fill_limit   = 600;

  typedef enum logic [2:0] {
    op_reset, op_lock, op_wr, op_rd, op_fill, op_rd_fill
  } op_t;

  // one stimulus row
  // fill rows use addr as base, op_rd_fill reads host address data[7:0]
  typedef struct packed {
    op_t               op;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [addr_w:0]   len;
    logic [data_w-1:0] seed;
    logic [data_w-1:0] expected;
  } row_t;

  logic              clk_bufg;
  logic              sys_rst;
  logic              pll_lock;
  logic              iodelay_ctrl_rdy;
  logic              rstdiv0;
  logic              host_cmd_valid;
  mem_req_t          host_cmd;
  logic              host_busy;
  logic              host_rdata_valid;
  logic [data_w-1:0] host_rdata;
  logic              fill_start;
  logic [addr_w-1:0] fill_base;
  logic [addr_w:0]   fill_len;
  logic [data_w-1:0] fill_seed;
  logic              fill_busy;
  logic              fill_done;

  row_t              table_rows [n_rows];
  // expected memory contents
  logic [data_w-1:0] ref_mem [256];
  int                mismatch_cnt;
  int                fail_cnt;
  // per-cycle observations, cleared per operation
  int                cyc;
  int                start_cyc;
  int                fill_writes;
  int                rd_pulses;
  int                done_pulses;
  int                rd_cyc;
  int                done_cyc;
  logic [data_w-1:0] rd_value;

  memsys_top #(
    .RST_ACT_LOW  (1),
    .RST_SYNC_NUM (rst_sync_num),
    .DEPTH        (256)
  ) UUT (
    .clk_bufg         (clk_bufg),
    .sys_rst          (sys_rst),
    .pll_lock         (pll_lock),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .rstdiv0          (rstdiv0),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd         (host_cmd),
    .host_busy        (host_busy),
    .host_rdata_valid (host_rdata_valid),
    .host_rdata       (host_rdata),
    .fill_start       (fill_start),
    .fill_base        (fill_base),
    .fill_len         (fill_len),
    .fill_seed        (fill_seed),
    .fill_busy        (fill_busy),
    .fill_done        (fill_done)
  );

  always #(clk_period / 2) clk_bufg = ~clk_bufg;

  // ************************************************************
  // reporting and sampling
  // ************************************************************

  task automatic report_mismatch(input string name, input logic [data_w-1:0] exp,
                                 input logic [data_w-1:0] act);
    mismatch_cnt++;
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
  endtask

  task automatic report_failure(input string what);
    fail_cnt++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic clear_counts();
    fill_writes = 0;
    rd_pulses   = 0;
    done_pulses = 0;
    rd_cyc      = -1;
    done_cyc    = -1;
  endtask

  // advance to the next falling edge, where outputs are stable
  task automatic sample_cycle();
    @(negedge clk_bufg);
    cyc++;
    if (UUT.grant[1] === 1'b1) begin
      fill_writes++;
    end
    if (host_rdata_valid === 1'b1) begin
      rd_pulses++;
      rd_value = host_rdata;
      if (rd_cyc < 0) rd_cyc = cyc;
    end
    if (fill_done === 1'b1) begin
      done_pulses++;
      if (done_cyc < 0) done_cyc = cyc;
    end
  endtask

  // everything that must be quiet while reset holds
  task automatic check_idle();
    if (host_busy !== 1'b0) report_mismatch("host_busy", '0, host_busy);
    if (host_rdata_valid !== 1'b0) report_mismatch("host_rdata_valid", '0, host_rdata_valid);
    if (fill_busy !== 1'b0) report_mismatch("fill_busy", '0, fill_busy);
    if (fill_done !== 1'b0) report_mismatch("fill_done", '0, fill_done);
    if (UUT.grant !== 2'b00) report_mismatch("grant", '0, UUT.grant);
  endtask

  // ************************************************************
  // reset sequencing
  // ************************************************************

  // release already driven on the last edge
  // high for edges 0 to n-1, low from edge n
  task automatic count_release(input int edges);
    for (int k = 0; k <= edges; k++) begin
      sample_cycle();
      if (rstdiv0 !== (k < edges)) report_mismatch("rstdiv0", (k < edges), rstdiv0);
    end
    check_idle();
  endtask

  task automatic do_reset(input row_t row);
    @(posedge clk_bufg);
    sys_rst <= 1'b0;
    repeat (2) begin
      sample_cycle();
      if (rstdiv0 !== 1'b1) report_mismatch("rstdiv0", 1, rstdiv0);
      check_idle();
    end
    @(posedge clk_bufg);
    sys_rst <= 1'b1;
    count_release(int'(row.expected));
  endtask

  // lock loss sets reset between edges, then delay ready holds it
  task automatic do_lock(input row_t row);
    @(posedge clk_bufg);
    pll_lock <= 1'b0;
    sample_cycle();
    if (rstdiv0 !== 1'b1) report_mismatch("rstdiv0", 1, rstdiv0);
    @(posedge clk_bufg);
    pll_lock         <= 1'b1;
    iodelay_ctrl_rdy <= 1'b0;
    repeat (2) begin
      sample_cycle();
      if (rstdiv0 !== 1'b1) report_mismatch("rstdiv0", 1, rstdiv0);
    end
    @(posedge clk_bufg);
    iodelay_ctrl_rdy <= 1'b1;
    count_release(int'(row.expected));
  endtask

  // ************************************************************
  // host port
  // ************************************************************

  task automatic host_issue(input logic cmd_we, input logic [addr_w-1:0] cmd_addr,
                            input logic [data_w-1:0] cmd_data);
    @(posedge clk_bufg);
    host_cmd_valid <= 1'b1;
    host_cmd       <= '{we: cmd_we, addr: cmd_addr, wdata: cmd_data};
    sample_cycle();
    @(posedge clk_bufg);
    host_cmd_valid <= 1'b0;
    sample_cycle();
  endtask

  task automatic wait_host_idle();
    int n;
    n = 0;
    while (host_busy !== 1'b0 && n < wait_limit) begin
      sample_cycle();
      n++;
    end
    if (host_busy !== 1'b0) report_failure("host_busy stuck high");
  endtask

  task automatic host_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    host_issue(1'b1, addr, data);
    wait_host_idle();
    ref_mem[addr] = data;
  endtask

  // one extra cycle after busy falls catches a second valid pulse
  task automatic host_read_check(input logic [addr_w-1:0] addr);
    logic [data_w-1:0] exp;
    exp = ref_mem[addr];
    clear_counts();
    host_issue(1'b0, addr, '0);
    wait_host_idle();
    sample_cycle();
    if (rd_pulses != 1) begin
      report_failure($sformatf("read of %h gave %0d valid pulses", addr, rd_pulses));
    end
    if (rd_value !== exp) report_mismatch("host_rdata", exp, rd_value);
    if (host_busy !== 1'b0) report_mismatch("host_busy", '0, host_busy);
  endtask

  // ************************************************************
  // fill engine
  // ************************************************************

  task automatic fill_issue(input row_t row);
    @(posedge clk_bufg);
    fill_start <= 1'b1;
    fill_base  <= row.addr;
    fill_len   <= row.len;
    fill_seed  <= row.seed;
    sample_cycle();
    start_cyc = cyc;
    @(posedge clk_bufg);
    fill_start <= 1'b0;
    sample_cycle();
  endtask

  // model update, then read back the range and its two neighbours
  task automatic fill_readback(input row_t row);
    for (int i = 0; i < int'(row.len); i++) begin
      ref_mem[8'(int'(row.addr) + i)] = row.seed + i;
    end
    if (row.len == 9'd256) begin
      for (int i = 0; i < 256; i++) host_read_check(8'(i));
    end else begin
      for (int i = -1; i <= int'(row.len); i++) host_read_check(8'(int'(row.addr) + i));
    end
  endtask

  task automatic do_fill(input row_t row);
    int n;
    clear_counts();
    fill_issue(row);
    n = 0;
    while (done_pulses == 0 && n < fill_limit) begin
      sample_cycle();
      n++;
    end
    sample_cycle();
    if (done_pulses != 1) report_failure($sformatf("%0d fill_done pulses", done_pulses));
    if (fill_busy !== 1'b0) report_mismatch("fill_busy", '0, fill_busy);
    if (fill_writes != int'(row.expected)) report_mismatch("fill writes", row.expected, fill_writes);
    // one write per cycle, done the cycle after the last one
    if (done_cyc != start_cyc + 1 + int'(row.len)) begin
      report_mismatch("fill_done cycle", start_cyc + 1 + int'(row.len), done_cyc);
    end
    fill_readback(row);
  endtask

  // host read outside the range, issued a few cycles into a long fill
  task automatic do_rd_fill(input row_t row);
    logic [addr_w-1:0] rd_addr;
    logic [data_w-1:0] exp;
    int                n;
    rd_addr = row.data[addr_w-1:0];
    exp     = ref_mem[rd_addr];
    clear_counts();
    fill_issue(row);
    repeat (3) sample_cycle();
    host_issue(1'b0, rd_addr, '0);
    n = 0;
    while ((done_pulses == 0 || host_busy !== 1'b0) && n < fill_limit) begin
      sample_cycle();
      n++;
    end
    sample_cycle();
    if (done_pulses != 1) report_failure($sformatf("%0d fill_done pulses", done_pulses));
    if (rd_pulses != 1) report_failure($sformatf("%0d host read pulses", rd_pulses));
    if (rd_cyc < 0 || rd_cyc >= done_cyc) report_failure("host read came after fill_done");
    if (rd_value !== exp) report_mismatch("host_rdata", exp, rd_value);
    if (fill_writes != int'(row.expected)) report_mismatch("fill writes", row.expected, fill_writes);
    fill_readback(row);
  endtask

  // ************************************************************
  // stimulus table
  // ************************************************************

  function automatic row_t make_row(input op_t row_op, input logic [addr_w-1:0] row_addr,
                                    input logic [data_w-1:0] row_data,
                                    input logic [addr_w:0] row_len,
                                    input logic [data_w-1:0] row_seed,
                                    input logic [data_w-1:0] row_exp);
    return '{op: row_op, addr: row_addr, data: row_data, len: row_len,
             seed: row_seed, expected: row_exp};
  endfunction

  // fill rows expect their write count, reset rows their release edges
  function automatic void build_table();
    table_rows[0]  = make_row(op_reset, 8'h00, '0, 9'd0, '0, rel_edges);
    // whole memory first, so every address has a known value
    table_rows[1]  = make_row(op_fill, 8'h00, '0, 9'd256, $urandom(), 256);
    table_rows[2]  = make_row(op_wr, 8'h35, $urandom(), 9'd0, '0, 0);
    table_rows[3]  = make_row(op_rd, 8'h35, '0, 9'd0, '0, 0);
    table_rows[4]  = make_row(op_wr, 8'h80, $urandom(), 9'd0, '0, 0);
    table_rows[5]  = make_row(op_rd, 8'h80, '0, 9'd0, '0, 0);
    table_rows[6]  = make_row(op_fill, 8'h40, '0, 9'd16, $urandom(), 16);
    // crosses 255 into 0
    table_rows[7]  = make_row(op_fill, 8'hf8, '0, 9'd16, $urandom(), 16);
    table_rows[8]  = make_row(op_fill, 8'h10, '0, 9'd0, $urandom(), 0);
    table_rows[9]  = make_row(op_lock, 8'h00, '0, 9'd0, '0, rel_edges);
    // contents survive the lock loss
    table_rows[10] = make_row(op_rd, 8'h35, '0, 9'd0, '0, 0);
    table_rows[11] = make_row(op_rd_fill, 8'h90, 32'h20, 9'd64, $urandom(), 64);
    table_rows[12] = make_row(op_rd, 8'h80, '0, 9'd0, '0, 0);
  endfunction

  initial begin
    clk_bufg         = 1'b0;
    sys_rst          = 1'b0;
    pll_lock         = 1'b1;
    iodelay_ctrl_rdy = 1'b1;
    host_cmd_valid   = 1'b0;
    host_cmd         = '0;
    fill_start       = 1'b0;
    fill_base        = '0;
    fill_len         = '0;
    fill_seed        = '0;
    mismatch_cnt     = 0;
    fail_cnt         = 0;
    cyc              = 0;
    start_cyc        = 0;
    rd_value         = '0;
    clear_counts();
    void'($urandom(32'h9836_5ae4));
    build_table();
    for (int r = 0; r < n_rows; r++) begin
      case (table_rows[r].op)
        op_reset:   do_reset(table_rows[r]);
        op_lock:    do_lock(table_rows[r]);
        op_wr:      host_write(table_rows[r].addr, table_rows[r].data);
        op_rd:      host_read_check(table_rows[r].addr);
        op_fill:    do_fill(table_rows[r]);
        op_rd_fill: do_rd_fill(table_rows[r]);
        default:    report_failure("unknown table operation");
      endcase
    end
    repeat (2) sample_cycle();
    $display("rows %0d, mismatches %0d, other errors %0d", n_rows, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog, 300 cycles per table row
  initial begin
    #(n_rows * 300 * clk_period);
    $display("watchdog expired after %0d cycles", n_rows * 300);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/memsys_pkg.sv
rtl/rst_sequencer.sv
rtl/mem_array.sv
rtl/mem_arbiter.sv
rtl/host_port.sv
rtl/fill_engine.sv
rtl/memsys_top.sv
tb/memsys_assert.sv
tb/memsys_tb.sv

// ==== Bender.yml ====
package:
  name: memsys

sources:
  # design, package first
  - files:
      - rtl/memsys_pkg.sv
      - rtl/rst_sequencer.sv
      - rtl/mem_array.sv
      - rtl/mem_arbiter.sv
      - rtl/host_port.sv
      - rtl/fill_engine.sv
      - rtl/memsys_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - tb/memsys_assert.sv
      - tb/memsys_tb.sv
